//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_if_stage
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := All tests passed
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the log holds the pass line
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/if_checker.sv
`timescale 1ns/1ps

module if_checker import if_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  stall_i,
  input  logic                  redirect_i,
  input  logic [XLEN-1:0]       redirect_pc_i,
  input  logic                  ar_valid_i,
  input  logic                  ar_ready_i,
  input  logic [XLEN-1:0]       ar_addr_i,
  input  logic                  r_valid_i,
  input  logic                  r_ready_i,
  input  logic [AXI_DATA_W-1:0] r_data_i,
  input  logic [AXI_RESP_W-1:0] r_resp_i,
  input  logic                  inst_valid_i,
  input  logic [INST_W-1:0]     inst_i,
  input  logic [XLEN-1:0]       inst_pc_i,
  input  logic                  inst_err_i,
  output int                    err_cnt_o,
  output int                    inst_cnt_o
);

  int                err_cnt = 0;
  int                inst_cnt = 0;
  // next address the fetch has to ask for
  logic [XLEN-1:0]   exp_pc;
  // exp_pc not requested yet
  logic              pending;
  // read on the bus from AR rise to R handshake
  logic              busy;
  logic              drop;
  logic [XLEN-1:0]   req_addr;
  // AR accepted and R still to come
  logic              r_wait;
  // AR has to rise in this cycle
  logic              launch_due;
  // AR left over from the cycle before
  logic              ar_held;
  // decode outputs due in this cycle
  logic              exp_valid;
  logic [INST_W-1:0] exp_inst;
  logic [XLEN-1:0]   exp_inst_pc;
  logic              exp_err;

  assign err_cnt_o = err_cnt;
  assign inst_cnt_o = inst_cnt;

  task automatic value_error(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] want);
    $display("[ERROR] %0t %s got %h expected %h", $time, name, got, want);
    err_cnt++;
  endtask

  // static prediction on a good word
  function automatic logic [XLEN-1:0] predict(input logic [XLEN-1:0] addr,
                                              input logic [INST_W-1:0] raw);
    inst_u              w;
    logic signed [20:0] j_off;
    logic signed [12:0] b_off;
    w = raw;
    j_off = {w.j_fmt.imm20, w.j_fmt.imm19_12, w.j_fmt.imm11, w.j_fmt.imm10_1, 1'b0};
    b_off = {w.b_fmt.imm12, w.b_fmt.imm11, w.b_fmt.imm10_5, w.b_fmt.imm4_1, 1'b0};
    if (w.j_fmt.opcode == OPC_JAL) begin
      return addr + XLEN'(j_off);
    end
    // only backward branches are taken
    if (w.b_fmt.opcode == OPC_BRANCH && b_off[12]) begin
      return addr + XLEN'(b_off);
    end
    return addr + 64'd4;
  endfunction

  // sampled mid cycle where inputs and outputs have settled
  always @(negedge clk) begin
    logic ar_rise;
    logic r_fire;
    if (!rst_n_i) begin
      exp_pc = RESET_PC;
      pending = 1'b1;
      busy = 1'b0;
      drop = 1'b0;
      r_wait = 1'b0;
      launch_due = 1'b0;
      ar_held = 1'b0;
      exp_valid = 1'b0;
    end else begin
      // delivery of last cycle's response
      if (inst_valid_i !== exp_valid) begin
        value_error("inst_valid_o", XLEN'(inst_valid_i), XLEN'(exp_valid));
      end else if (exp_valid) begin
        inst_cnt++;
        if (inst_i !== exp_inst) value_error("inst_o", XLEN'(inst_i), XLEN'(exp_inst));
        if (inst_pc_i !== exp_inst_pc) value_error("inst_pc_o", inst_pc_i, exp_inst_pc);
        if (inst_err_i !== exp_err) value_error("inst_err_o", XLEN'(inst_err_i), XLEN'(exp_err));
      end
      exp_valid = 1'b0;
      // r ready only while an accepted read waits for its data
      if (r_ready_i !== r_wait) begin
        value_error("axi_r_ready_o", XLEN'(r_ready_i), XLEN'(r_wait));
      end
      // new request
      ar_rise = ar_valid_i & ~ar_held;
      if (ar_rise && !launch_due) begin
        $display("%0t: AR raised while stalled, busy or without a new pc", $time);
        err_cnt++;
      end else if (!ar_rise && launch_due) begin
        $display("%0t: AR not raised although a new pc was ready", $time);
        err_cnt++;
      end
      if (ar_rise) begin
        if (ar_addr_i !== exp_pc) value_error("axi_ar_addr_o", ar_addr_i, exp_pc);
        req_addr = ar_addr_i;
        busy = 1'b1;
        drop = 1'b0;
        pending = 1'b0;
      end
      ar_held = ar_valid_i & ~ar_ready_i;
      // response
      r_fire = r_valid_i & r_ready_i;
      if (r_fire) begin
        if (!busy) begin
          $display("%0t: R handshake with no read outstanding", $time);
          err_cnt++;
        end
        busy = 1'b0;
        r_wait = 1'b0;
        // a redirect in the handshake cycle also kills it
        if (!drop && !redirect_i) begin
          exp_valid = 1'b1;
          exp_err = (r_resp_i != RESP_OKAY);
          exp_inst = exp_err ? NOP_INST : r_data_i[INST_W-1:0];
          exp_inst_pc = req_addr;
          exp_pc = exp_err ? req_addr + 64'd4 : predict(req_addr, r_data_i[INST_W-1:0]);
          pending = 1'b1;
        end
      end
      if (ar_valid_i && ar_ready_i) begin
        r_wait = 1'b1;
      end
      if (redirect_i) begin
        exp_pc = redirect_pc_i;
        pending = 1'b1;
        if (busy) drop = 1'b1;
      end
      launch_due = pending & ~busy & ~stall_i;
    end
  end

endmodule

//--- bench/if_stage_props.sv
`timescale 1ns/1ps

module if_stage_props import if_pkg::*; (
  input logic            clk,
  input logic            rst_n_i,
  input logic            ar_valid_i,
  input logic            ar_ready_i,
  input logic [XLEN-1:0] ar_addr_i,
  input logic            r_ready_i,
  input logic            inst_valid_i,
  input logic            inst_err_i
);

  // failed assertions so far
  int fail_cnt = 0;

  // request and address hold until accepted
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
    else begin
      $error("AR request changed before it was accepted");
      fail_cnt++;
    end

  // control outputs quiet after a reset edge
  reset_quiet: assert property (@(posedge clk)
    !rst_n_i |=> !ar_valid_i && !r_ready_i && !inst_valid_i && !inst_err_i)
    else begin
      $error("control output high right after a reset edge");
      fail_cnt++;
    end

  // decode strobe is a single pulse
  valid_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    inst_valid_i |=> !inst_valid_i)
    else begin
      $error("inst_valid_o high for two cycles in a row");
      fail_cnt++;
    end

endmodule

bind if_stage if_stage_props u_if_stage_props (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .ar_valid_i   (axi_ar_valid_o),
  .ar_ready_i   (axi_ar_ready_i),
  .ar_addr_i    (axi_ar_addr_o),
  .r_ready_i    (axi_r_ready_o),
  .inst_valid_i (inst_valid_o),
  .inst_err_i   (inst_err_o)
);

//--- bench/tb_if_stage.sv
`timescale 1ns/1ps

module tb_if_stage import if_pkg::*; ();

  logic                  clk;
  logic                  rst_n_i;
  logic                  stall_i;
  logic                  redirect_i;
  logic [XLEN-1:0]       redirect_pc_i;
  logic                  axi_ar_ready_i;
  logic                  axi_ar_valid_o;
  logic [XLEN-1:0]       axi_ar_addr_o;
  logic                  axi_r_ready_o;
  logic                  axi_r_valid_i;
  logic [AXI_DATA_W-1:0] axi_r_data_i;
  logic [AXI_RESP_W-1:0] axi_r_resp_i;
  logic                  axi_r_last_i;
  logic                  inst_valid_o;
  logic [INST_W-1:0]     inst_o;
  logic [XLEN-1:0]       inst_pc_o;
  logic                  inst_err_o;
  integer                seed;
  int                    chk_err;
  int                    inst_cnt;
  int                    bench_err;

  if_stage UUT (.*);

  if_checker u_if_checker (
    .clk (clk), .rst_n_i (rst_n_i), .stall_i (stall_i),
    .redirect_i (redirect_i), .redirect_pc_i (redirect_pc_i),
    .ar_valid_i (axi_ar_valid_o), .ar_ready_i (axi_ar_ready_i), .ar_addr_i (axi_ar_addr_o),
    .r_valid_i (axi_r_valid_i), .r_ready_i (axi_r_ready_o),
    .r_data_i (axi_r_data_i), .r_resp_i (axi_r_resp_i),
    .inst_valid_i (inst_valid_o), .inst_i (inst_o), .inst_pc_i (inst_pc_o),
    .inst_err_i (inst_err_o), .err_cnt_o (chk_err), .inst_cnt_o (inst_cnt)
  );

  // 40 ns period
  always #20 clk = ~clk;

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // random word with the opcode forced to jal, branch or something plain
  function automatic logic [INST_W-1:0] make_word();
    logic [INST_W-1:0] w;
    w = $random(seed);
    case (rand_below(3))
      // imm bit 1 cleared so targets stay 4-aligned
      0: begin
        w[6:0] = OPC_JAL;
        w[21] = 1'b0;
      end
      1: begin
        w[6:0] = OPC_BRANCH;
        w[8] = 1'b0;
      end
      default: begin
        if (w[6:0] == OPC_JAL || w[6:0] == OPC_BRANCH) begin
          w[6:0] = 7'b0110011;
        end
      end
    endcase
    return w;
  endfunction

  // instruction memory serving one read at a time
  task automatic serve_memory();
    int n;
    forever begin
      n = 0;
      while (axi_ar_valid_o !== 1'b1 && n < 100) begin
        @(posedge clk);
        #2;
        n++;
      end
      if (axi_ar_valid_o !== 1'b1) begin
        $display("%0t: no AR request seen for 100 cycles", $time);
        bench_err++;
      end else begin
        repeat (rand_below(6)) begin
          @(posedge clk);
          #2;
        end
        axi_ar_ready_i = 1'b1;
        @(posedge clk);
        #2;
        axi_ar_ready_i = 1'b0;
        repeat (rand_below(6)) begin
          @(posedge clk);
          #2;
        end
        axi_r_data_i = {$random(seed), make_word()};
        // slverr about one time in 16
        axi_r_resp_i = (rand_below(16) == 0) ? 2'b10 : RESP_OKAY;
        axi_r_last_i = 1'b1;
        axi_r_valid_i = 1'b1;
        n = 0;
        while (axi_r_ready_o !== 1'b1 && n < 20) begin
          @(posedge clk);
          #2;
          n++;
        end
        if (axi_r_ready_o !== 1'b1) begin
          $display("%0t: R response never accepted", $time);
          bench_err++;
        end
        @(posedge clk);
        #2;
        axi_r_valid_i = 1'b0;
        axi_r_last_i = 1'b0;
      end
    end
  endtask

  // random stall spans and redirect pulses
  task automatic run_traffic(input int cycles);
    int stall_left;
    stall_left = 0;
    repeat (cycles) begin
      @(posedge clk);
      #2;
      if (stall_left > 0) stall_left--;
      else if (rand_below(6) == 0) stall_left = 1 + rand_below(8);
      stall_i = (stall_left > 0);
      redirect_i = (rand_below(24) == 0);
      redirect_pc_i = {32'h0, $random(seed)} & ~64'h3;
    end
    stall_i = 1'b0;
    redirect_i = 1'b0;
  endtask

  initial begin
    int target;
    int n;
    seed = 32'hd325885f;
    bench_err = 0;
    clk = 1'b0;
    rst_n_i = 1'b0;
    stall_i = 1'b0;
    redirect_i = 1'b0;
    redirect_pc_i = '0;
    axi_ar_ready_i = 1'b0;
    axi_r_valid_i = 1'b0;
    axi_r_data_i = '0;
    axi_r_resp_i = RESP_OKAY;
    axi_r_last_i = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    fork
      serve_memory();
    join_none
    run_traffic(3000);
    // free running tail where fetch has to keep going
    target = inst_cnt + 8;
    n = 0;
    while (inst_cnt < target && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (inst_cnt < target) begin
      $display("%0t: fetch stopped delivering instructions", $time);
      bench_err++;
    end
    if (inst_cnt < 100) begin
      $display("only %0d instructions delivered in the whole run", inst_cnt);
      bench_err++;
    end
    $display("checker errors %0d, assertion errors %0d, bench errors %0d, instructions %0d",
             chk_err, UUT.u_if_stage_props.fail_cnt, bench_err, inst_cnt);
    if (chk_err + UUT.u_if_stage_props.fail_cnt + bench_err == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- build.f
rtl/if_pkg.sv
rtl/pc_predict.sv
rtl/axi_fetch_master.sv
rtl/inst_predecode.sv
rtl/if_stage.sv
bench/if_stage_props.sv
bench/if_checker.sv
bench/tb_if_stage.sv

//--- rtl/axi_fetch_master.sv
`timescale 1ns/1ps

module axi_fetch_master import if_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  pc_ready,
  input  logic [XLEN-1:0]       fetch_pc,
  input  logic                  redirect_i,
  output logic                  ar_fire,
  input  logic                  axi_ar_ready_i,
  output logic                  axi_ar_valid_o,
  output logic [XLEN-1:0]       axi_ar_addr_o,
  output logic                  axi_r_ready_o,
  input  logic                  axi_r_valid_i,
  input  logic [AXI_DATA_W-1:0] axi_r_data_i,
  input  logic [AXI_RESP_W-1:0] axi_r_resp_i,
  input  logic                  axi_r_last_i,
  output logic                  rsp_take,
  output logic [INST_W-1:0]     rsp_word,
  output logic                  rsp_err
);

  logic [1:0]      state_q;
  // first cycle of a raised AR
  logic            ar_first_q;
  // outstanding read belongs to an old pc
  logic            drop_q;
  // address held under AR back-pressure
  logic [XLEN-1:0] addr_q;
  logic            r_fire;
  logic            drop_now;
  // start a new read at the next edge
  logic            launch;

  assign axi_ar_valid_o = (state_q == ST_ADDR);
  assign axi_r_ready_o = (state_q == ST_DATA);

  // pc register was loaded at the edge that raised AR,
  // afterwards the copy keeps the address still
  assign axi_ar_addr_o = ar_first_q ? fetch_pc : addr_q;

  // stale acceptances leave the fresh pc alone
  assign ar_fire = axi_ar_valid_o & axi_ar_ready_i & ~drop_q;
  assign r_fire = axi_r_ready_o & axi_r_valid_i;

  // redirect in the handshake cycle also kills the response
  assign drop_now = drop_q | redirect_i;
  assign rsp_take = r_fire & ~drop_now;

  // 4-aligned fetch, word sits in the low half
  // single beat reads so r_last carries nothing new
  assign rsp_word = axi_r_data_i[INST_W-1:0];
  assign rsp_err = (axi_r_resp_i != RESP_OKAY);

  // back to back from the R handshake, else from idle
  assign launch = pc_ready & ((state_q == ST_IDLE) | r_fire);

  // one read in flight at most
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (launch) begin
            state_q <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (axi_ar_ready_i) begin
            state_q <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (axi_r_valid_i) begin
            state_q <= launch ? ST_ADDR : ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ar_first_q <= 1'b0;
    end else begin
      ar_first_q <= launch;
    end
  end

  // hold whatever went out this cycle
  always_ff @(posedge clk) begin
    addr_q <= axi_ar_addr_o;
  end

  // drop marker lives until the stale R handshake
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      drop_q <= 1'b0;
    end else if (r_fire) begin
      drop_q <= 1'b0;
    end else if (redirect_i && state_q != ST_IDLE) begin
      drop_q <= 1'b1;
    end
  end

endmodule

//--- rtl/if_pkg.sv
package if_pkg;

  // address and pc width
  localparam int XLEN = 64;
  // one fetched instruction
  localparam int INST_W = 32;
  // axi read data bus
  localparam int AXI_DATA_W = 64;
  localparam int AXI_RESP_W = 2;

  // first fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;
  // addi x0,x0,0 handed to decode on a bus error
  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;

  // major opcodes seen by the predecoder
  localparam logic [6:0] OPC_JAL = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // axi response codes
  localparam logic [AXI_RESP_W-1:0] RESP_OKAY = 2'b00;

  // fetch master states
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_ADDR = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;

  // j-type layout, immediate bits scattered
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // b-type layout, sign bit on top as usual
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // same instruction word, two decodings
  typedef union packed {
    j_fmt_t j_fmt;
    b_fmt_t b_fmt;
  } inst_u;

endpackage

//--- rtl/if_stage.sv
`timescale 1ns/1ps

module if_stage import if_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  // decode side
  input  logic                  stall_i,
  output logic                  inst_valid_o,
  output logic [INST_W-1:0]     inst_o,
  output logic [XLEN-1:0]       inst_pc_o,
  output logic                  inst_err_o,
  // execute side
  input  logic                  redirect_i,
  input  logic [XLEN-1:0]       redirect_pc_i,
  // axi read address channel
  input  logic                  axi_ar_ready_i,
  output logic                  axi_ar_valid_o,
  output logic [XLEN-1:0]       axi_ar_addr_o,
  // axi read data channel
  output logic                  axi_r_ready_o,
  input  logic                  axi_r_valid_i,
  input  logic [AXI_DATA_W-1:0] axi_r_data_i,
  input  logic [AXI_RESP_W-1:0] axi_r_resp_i,
  input  logic                  axi_r_last_i
);

  // pc toward the master
  logic [XLEN-1:0]   fetch_pc;
  logic              pc_ready;
  logic              ar_fire;
  // accepted response toward pc and decode
  logic              rsp_take;
  logic [INST_W-1:0] rsp_word;
  logic              rsp_err;
  // predicted next pc from the returned word
  logic [XLEN-1:0]   pred_pc;

  pc_predict u_pc_predict (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .rsp_take      (rsp_take),
    .pred_pc       (pred_pc),
    .ar_fire       (ar_fire),
    .fetch_pc      (fetch_pc),
    .pc_ready      (pc_ready)
  );

  axi_fetch_master u_axi_fetch_master (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .pc_ready       (pc_ready),
    .fetch_pc       (fetch_pc),
    .redirect_i     (redirect_i),
    .ar_fire        (ar_fire),
    .axi_ar_ready_i (axi_ar_ready_i),
    .axi_ar_valid_o (axi_ar_valid_o),
    .axi_ar_addr_o  (axi_ar_addr_o),
    .axi_r_ready_o  (axi_r_ready_o),
    .axi_r_valid_i  (axi_r_valid_i),
    .axi_r_data_i   (axi_r_data_i),
    .axi_r_resp_i   (axi_r_resp_i),
    .axi_r_last_i   (axi_r_last_i),
    .rsp_take       (rsp_take),
    .rsp_word       (rsp_word),
    .rsp_err        (rsp_err)
  );

  inst_predecode u_inst_predecode (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .rsp_take     (rsp_take),
    .rsp_word     (rsp_word),
    .rsp_err      (rsp_err),
    .fetch_pc     (fetch_pc),
    .pred_pc      (pred_pc),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .inst_pc_o    (inst_pc_o),
    .inst_err_o   (inst_err_o)
  );

endmodule

//--- rtl/inst_predecode.sv
`timescale 1ns/1ps

module inst_predecode import if_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              rsp_take,
  input  logic [INST_W-1:0] rsp_word,
  input  logic              rsp_err,
  input  logic [XLEN-1:0]   fetch_pc,
  output logic [XLEN-1:0]   pred_pc,
  output logic              inst_valid_o,
  output logic [INST_W-1:0] inst_o,
  output logic [XLEN-1:0]   inst_pc_o,
  output logic              inst_err_o
);

  inst_u           word;
  logic [XLEN-1:0] j_imm;
  logic [XLEN-1:0] b_imm;
  logic            is_jal;
  // conditional branch pointing backward
  logic            is_back_br;

  assign word = rsp_word;

  // jal offset, 21 bits sign extended
  assign j_imm = {{(XLEN-20){word.j_fmt.imm20}},
                  word.j_fmt.imm19_12,
                  word.j_fmt.imm11,
                  word.j_fmt.imm10_1,
                  1'b0};

  // branch offset, 13 bits sign extended
  assign b_imm = {{(XLEN-12){word.b_fmt.imm12}},
                  word.b_fmt.imm11,
                  word.b_fmt.imm10_5,
                  word.b_fmt.imm4_1,
                  1'b0};

  assign is_jal = (word.j_fmt.opcode == OPC_JAL);
  // loops mostly close backward, so take those
  assign is_back_br = (word.b_fmt.opcode == OPC_BRANCH) & word.b_fmt.imm12;

  // static prediction
  // fetch_pc is still the address of this read
  always_comb begin
    if (rsp_err) begin
      pred_pc = fetch_pc + XLEN'(4);
    end else if (is_jal) begin
      pred_pc = fetch_pc + j_imm;
    end else if (is_back_br) begin
      pred_pc = fetch_pc + b_imm;
    end else begin
      pred_pc = fetch_pc + XLEN'(4);
    end
  end

  // strobe and error flag toward decode
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      inst_valid_o <= 1'b0;
      inst_err_o <= 1'b0;
    end else begin
      inst_valid_o <= rsp_take;
      if (rsp_take) begin
        inst_err_o <= rsp_err;
      end
    end
  end

  // instruction and its pc
  // faulted fetch turns into a nop
  always_ff @(posedge clk) begin
    if (rsp_take) begin
      inst_o <= rsp_err ? NOP_INST : rsp_word;
      inst_pc_o <= fetch_pc;
    end
  end

endmodule

//--- rtl/pc_predict.sv
`timescale 1ns/1ps

module pc_predict import if_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            stall_i,
  input  logic            redirect_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  input  logic            rsp_take,
  input  logic [XLEN-1:0] pred_pc,
  input  logic            ar_fire,
  output logic [XLEN-1:0] fetch_pc,
  output logic            pc_ready
);

  // pc not yet sent out on AR
  logic fresh_q;
  // pc gets a new value at this edge
  logic pc_load;

  assign pc_load = redirect_i | rsp_take;

  // pc register
  // execute wins over the predictor
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      fetch_pc <= RESET_PC;
    end else if (redirect_i) begin
      fetch_pc <= redirect_pc_i;
    end else if (rsp_take) begin
      fetch_pc <= pred_pc;
    end
  end

  // fresh flag
  // reset counts as a load of RESET_PC
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      fresh_q <= 1'b1;
    end else if (pc_load) begin
      fresh_q <= 1'b1;
    end else if (ar_fire) begin
      fresh_q <= 1'b0;
    end
  end

  // a load at this edge already counts as fresh,
  // so the master can raise AR right in the next cycle
  // decode stall only holds back a new request
  assign pc_ready = (fresh_q | pc_load) & ~stall_i;

endmodule
